/* tb.f */
common/halfband_pkg.sv
halfband/halfband_sym_filter.sv
halfband/zero_stuffer.sv
source/rate_strobe_gen.sv
source/wb_ctrl_regs.sv
source/interp_top.sv
test/interp_assert.sv
test/interp_tb.sv

/* Bender.yml */
package:
  name: halfband_interp

sources:
  - files:
      - common/halfband_pkg.sv
      - halfband/halfband_sym_filter.sv
      - halfband/zero_stuffer.sv
      - source/rate_strobe_gen.sv
      - source/wb_ctrl_regs.sv
      - source/interp_top.sv
  - target: test
    files:
      - test/interp_assert.sv
      - test/interp_tb.sv

/* test/interp_tb.sv */
`timescale 1ns/10ps

module interp_tb;
    import halfband_pkg::*;

    localparam rate_div_t DEFAULT_DIV = 16'd5;
    localparam int        NUM_ROWS    = 5;

    localparam int PAT_IMPULSE = 0;
    localparam int PAT_DC      = 1;
    localparam int PAT_RAMP    = 2;
    localparam int PAT_RANDOM  = 3;

    // stimulus table, expected count is four outputs per input sample.
    string row_name [NUM_ROWS] = '{"impulse", "dc_level", "ramp", "random_a", "random_b"};
    int    row_div  [NUM_ROWS] = '{0, 2, 1, 3, 6};
    int    row_pat  [NUM_ROWS] = '{PAT_IMPULSE, PAT_DC, PAT_RAMP, PAT_RANDOM, PAT_RANDOM};
    int    row_exp  [NUM_ROWS] = '{32, 48, 64, 96, 96};

    logic     sys_clk;
    logic     reset;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    sample_t  sample_in;
    logic     sample_take;
    sample_t  sample_out;
    logic     out_valid;

    integer   seed = 32'h4df71050;
    string    cur_test = "reset";
    int       cur_pattern = PAT_IMPULSE;
    int       cur_div = 0;
    int       stream_id = 0;
    int       stop_count = 0;
    int       out_total = 0;
    int       take_total = 0;

    // monitor state.
    int       tb_phase = 0;
    int       stops_seen = 0;
    int       gap = 0;
    logic     spacing_armed = 1'b0;
    logic     take_pending = 1'b0;
    sample_t  take_sample = '0;

    // golden model state, index 0 is stage 1.
    sample_t  fir_dly  [0:1][0:6] = '{default: '0};
    sample_t  fir_pipe [0:1][0:3] = '{default: '0};
    sample_t  hb1_y = '0;
    sample_t  st1_held = '0;
    sample_t  st2_held = '0;
    logic     st1_zero = 1'b1;
    logic     st2_zero = 1'b1;

    interp_top #(
        .HB1              (HB1_COEFS),
        .HB2              (HB2_COEFS),
        .DEFAULT_RATE_DIV (DEFAULT_DIV)
    ) UUT (
        .sys_clk     (sys_clk),
        .reset       (reset),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .sample_in   (sample_in),
        .sample_take (sample_take),
        .sample_out  (sample_out),
        .out_valid   (out_valid)
    );

    initial begin
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("Error: test %s, %s expected %h, actual %h",
                                cur_test, what, expected, actual));
        end
    endtask

    function automatic sample_t next_sample(input int pat, input int idx);
        case (pat)
            PAT_IMPULSE: return (idx == 0) ? sample_t'(131071) : sample_t'(0);
            PAT_DC:      return sample_t'(90000);
            PAT_RAMP:    return sample_t'(idx * 4099 - 60000);
            default:     return sample_t'($random(seed));
        endcase
    endfunction

    // one enable tick of a 7-tap halfband, four ticks of latency.
    task automatic filter_step(input int st, input sample_t x, input coef_set_t c,
                               output sample_t y);
        sample_t pair [0:3];
        sample_t term [0:3];
        sample_t lvl_a;
        sample_t lvl_b;
        longint  prod;
        for (int i = 6; i > 0; i--) begin
            fir_dly[st][i] = fir_dly[st][i-1];
        end
        fir_dly[st][0] = x >>> 1;
        for (int i = 0; i < 3; i++) begin
            pair[i] = fir_dly[st][i] + fir_dly[st][6-i];
        end
        pair[3] = fir_dly[st][3];
        // keep product bits 34..17.
        for (int i = 0; i < 4; i++) begin
            prod    = longint'(c[i]) * longint'(pair[i]);
            term[i] = sample_t'(prod >>> 17);
        end
        lvl_a = term[0] + term[1];
        lvl_b = term[2] + term[3];
        y = fir_pipe[st][3];
        for (int i = 3; i > 0; i--) begin
            fir_pipe[st][i] = fir_pipe[st][i-1];
        end
        fir_pipe[st][0] = lvl_a + lvl_b;
    endtask

    // one output tick; even phases are stage 1 ticks, phase 0 loads a new input.
    task automatic model_step(input int phase, input sample_t fresh, output sample_t y_out);
        sample_t st1_out;
        sample_t st2_out;
        sample_t hb1_prev;
        logic    mid;
        mid      = (phase % 2) == 0;
        st1_out  = st1_zero ? sample_t'(0) : st1_held;
        st2_out  = st2_zero ? sample_t'(0) : st2_held;
        hb1_prev = hb1_y;
        if (mid) begin
            filter_step(0, st1_out, HB1_COEFS, hb1_y);
            st2_held = hb1_prev;
            st2_zero = 1'b0;
        end else begin
            st2_zero = !st2_zero;
        end
        filter_step(1, st2_out, HB2_COEFS, y_out);
        if (phase == 0) begin
            st1_held = fresh;
            st1_zero = 1'b0;
        end else if (mid) begin
            st1_zero = !st1_zero;
        end
    endtask

    task automatic wait_ack();
        int waited;
        waited = 0;
        do begin
            @(posedge sys_clk);
            #1;
            waited++;
            if (waited > 8) begin
                abort_run("no wb_ack came back within 8 cycles");
            end
        end while (!wb_ack);
        check_value("wb_ack latency", 1, waited);
    endtask

    task automatic bus_write(input wb_addr_t addr, input wb_data_t data);
        @(posedge sys_clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = addr;
        wb_dat_w = data;
        wait_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_read(input wb_addr_t addr, output wb_data_t data);
        @(posedge sys_clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = addr;
        wait_ack();
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // clear run, then let the monitor restart its phase count.
    task automatic stop_run();
        bus_write(REG_CTRL, 32'd0);
        repeat (2) @(posedge sys_clk);
        #1;
        stop_count++;
    endtask

    task automatic run_row(input int r);
        wb_data_t rd;
        sample_t  held_out;
        int       out_base;
        cur_test    = row_name[r];
        cur_div     = row_div[r];
        cur_pattern = row_pat[r];
        stream_id++;
        bus_write(REG_RATE_DIV, wb_data_t'(row_div[r]));
        bus_write(REG_SAMPLE_COUNT, 32'd0);
        bus_read(REG_SAMPLE_COUNT, rd);
        check_value("SAMPLE_COUNT after clear", 0, rd);
        out_base = out_total;
        bus_write(REG_CTRL, 32'd1);
        bus_read(REG_CTRL, rd);
        check_value("CTRL readback", 1, rd);
        while ((out_total - out_base) < row_exp[r] / 2) begin
            @(posedge sys_clk);
        end
        // pause halfway, everything must freeze.
        stop_run();
        held_out = sample_out;
        repeat (20) begin
            @(posedge sys_clk);
            #1;
            if (sample_take || out_valid) begin
                abort_run("sample_take or out_valid fired while run was cleared");
            end
            check_value("sample_out hold", held_out, sample_out);
        end
        bus_write(REG_CTRL, 32'd1);
        while ((out_total - out_base) < row_exp[r]) begin
            @(posedge sys_clk);
        end
        stop_run();
        bus_read(REG_SAMPLE_COUNT, rd);
        check_value("SAMPLE_COUNT", out_total - out_base, rd);
    endtask

    // sample source, advances one step after each take.
    initial begin : stimulus
        int seen_stream;
        int seen_takes;
        int idx;
        sample_in   = '0;
        seen_stream = 0;
        seen_takes  = 0;
        idx         = 0;
        forever begin
            @(posedge sys_clk);
            #1;
            if (stream_id != seen_stream) begin
                seen_stream = stream_id;
                seen_takes  = take_total;
                idx         = 0;
                sample_in   = next_sample(cur_pattern, idx);
            end else if (take_total != seen_takes) begin
                seen_takes = take_total;
                idx++;
                sample_in = next_sample(cur_pattern, idx);
            end
        end
    end

    // outputs are stable at the falling edge.
    always @(negedge sys_clk) begin
        sample_t expected;
        if (!reset) begin
            if (stop_count != stops_seen) begin
                stops_seen    = stop_count;
                tb_phase      = 0;
                spacing_armed = 1'b0;
            end
            gap++;
            if (out_valid) begin
                if (take_pending != (tb_phase == 0)) begin
                    abort_run("sample_take is not aligned with every fourth out_valid");
                end
                model_step(tb_phase, take_sample, expected);
                check_value("sample_out", expected, sample_out);
                if (spacing_armed) begin
                    check_value("out_valid spacing", cur_div + 1, gap);
                end
                spacing_armed = 1'b1;
                gap           = 0;
                tb_phase      = (tb_phase + 1) % 4;
                out_total++;
            end else if (take_pending) begin
                abort_run("sample_take was not followed by out_valid");
            end
            take_pending = sample_take;
            if (sample_take) begin
                take_sample = sample_in;
                take_total++;
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = 5000;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += row_exp[r] * (row_div[r] + 1);
        end
        repeat (limit) @(posedge sys_clk);
        abort_run("watchdog expired before all tests finished");
    end

    initial begin
        wb_data_t rd;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (2) @(posedge sys_clk);
        #1;
        reset = 1'b0;
        check_value("out_valid after reset", 0, out_valid);
        check_value("sample_take after reset", 0, sample_take);
        check_value("wb_ack after reset", 0, wb_ack);
        bus_read(REG_CTRL, rd);
        check_value("CTRL after reset", 0, rd);
        bus_read(REG_RATE_DIV, rd);
        check_value("RATE_DIV after reset", DEFAULT_DIV, rd);
        bus_write(REG_RATE_DIV, 32'h0000_a5c3);
        bus_read(REG_RATE_DIV, rd);
        check_value("RATE_DIV readback", 32'h0000_a5c3, rd);
        // unmapped word reads zero.
        bus_write(4'd9, 32'hdead_beef);
        bus_read(4'd9, rd);
        check_value("unmapped readback", 0, rd);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        if (out_total > 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run("no output samples were produced");
        end
    end

endmodule

/* test/interp_assert.sv */
`timescale 1ns/10ps

module interp_assert (
    input logic sys_clk,
    input logic reset,
    input logic wb_ack,
    input logic run,
    input logic out_en,
    input logic mid_en,
    input logic in_en
);

    // ack is a single pulse in a classic cycle.
    ack_single: assert property (
        @(posedge sys_clk) disable iff (reset) wb_ack |=> !wb_ack
    ) else $error("wb_ack stayed high for more than one cycle");

    // input strobe sits on both faster strobes.
    in_aligned: assert property (
        @(posedge sys_clk) disable iff (reset) in_en |-> (mid_en && out_en)
    ) else $error("in_en fired without mid_en and out_en");

    // stopped means no strobe at all.
    stopped_quiet: assert property (
        @(posedge sys_clk) disable iff (reset) !run |-> !(out_en || mid_en || in_en)
    ) else $error("a rate strobe fired while run was low");

endmodule

bind interp_top interp_assert u_assert (
    .sys_clk (sys_clk),
    .reset   (reset),
    .wb_ack  (wb_ack),
    .run     (run),
    .out_en  (out_en),
    .mid_en  (mid_en),
    .in_en   (in_en)
);

/* source/interp_top.sv */
`timescale 1ns/10ps

module interp_top #(
    parameter halfband_pkg::coef_set_t HB1              = halfband_pkg::HB1_COEFS,
    parameter halfband_pkg::coef_set_t HB2              = halfband_pkg::HB2_COEFS,
    parameter halfband_pkg::rate_div_t DEFAULT_RATE_DIV = 16'd3
) (
    input  logic                   sys_clk,
    input  logic                   reset,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  halfband_pkg::wb_addr_t wb_adr,
    input  halfband_pkg::wb_data_t wb_dat_w,
    output halfband_pkg::wb_data_t wb_dat_r,
    output logic                   wb_ack,
    input  halfband_pkg::sample_t  sample_in,
    output logic                   sample_take,
    output halfband_pkg::sample_t  sample_out,
    output logic                   out_valid
);
    import halfband_pkg::*;

    logic      run;
    rate_div_t rate_div;
    logic      out_en;
    logic      mid_en;
    logic      in_en;
    sample_t   stuff1_out;
    sample_t   hb1_out;
    sample_t   stuff2_out;

    wb_ctrl_regs #(
        .DEFAULT_RATE_DIV (DEFAULT_RATE_DIV)
    ) u_regs (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .out_valid (out_valid),
        .run       (run),
        .rate_div  (rate_div)
    );

    rate_strobe_gen u_rates (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .run      (run),
        .rate_div (rate_div),
        .out_en   (out_en),
        .mid_en   (mid_en),
        .in_en    (in_en)
    );

    // input is taken on the slowest strobe.
    assign sample_take = in_en;

    // stage 1, input rate to twice input rate.
    zero_stuffer u_stuff1 (
        .sys_clk (sys_clk),
        .reset   (reset),
        .load_en (in_en),
        .fast_en (mid_en),
        .din     (sample_in),
        .dout    (stuff1_out)
    );

    halfband_sym_filter #(
        .COEFS (HB1)
    ) u_hb1 (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .sample_en (mid_en),
        .x_in      (stuff1_out),
        .y         (hb1_out)
    );

    // stage 2, up to the output rate.
    zero_stuffer u_stuff2 (
        .sys_clk (sys_clk),
        .reset   (reset),
        .load_en (mid_en),
        .fast_en (out_en),
        .din     (hb1_out),
        .dout    (stuff2_out)
    );

    halfband_sym_filter #(
        .COEFS (HB2)
    ) u_hb2 (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .sample_en (out_en),
        .x_in      (stuff2_out),
        .y         (sample_out)
    );

    // filter output register updates on out_en, valid one clock later.
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= out_en;
        end
    end

endmodule

/* source/wb_ctrl_regs.sv */
`timescale 1ns/10ps

module wb_ctrl_regs #(
    parameter halfband_pkg::rate_div_t DEFAULT_RATE_DIV = 16'd3
) (
    input  logic                    sys_clk,
    input  logic                    reset,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  halfband_pkg::wb_addr_t  wb_adr,
    input  halfband_pkg::wb_data_t  wb_dat_w,
    output halfband_pkg::wb_data_t  wb_dat_r,
    output logic                    wb_ack,
    input  logic                    out_valid,
    output logic                    run,
    output halfband_pkg::rate_div_t rate_div
);
    import halfband_pkg::*;

    logic     bus_hit;
    logic     bus_write;
    wb_data_t sample_count;

    // new cycle only while ack is low, so ack lasts one clock.
    assign bus_hit   = wb_cyc && wb_stb && !wb_ack;
    assign bus_write = bus_hit && wb_we;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= bus_hit;
        end
    end

    // writes land on the ack edge.
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            run      <= 1'b0;
            rate_div <= DEFAULT_RATE_DIV;
        end else if (bus_write) begin
            case (wb_adr)
                REG_CTRL:     run      <= wb_dat_w[0];
                REG_RATE_DIV: rate_div <= wb_dat_w[RATE_DIV_W-1:0];
                default:      ;
            endcase
        end
    end

    // output sample counter, any write clears it.
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            sample_count <= '0;
        end else if (bus_write && (wb_adr == REG_SAMPLE_COUNT)) begin
            sample_count <= '0;
        end else if (out_valid) begin
            sample_count <= sample_count + 1'b1;
        end
    end

    // read data sits beside ack.
    always_ff @(posedge sys_clk) begin
        if (bus_hit) begin
            case (wb_adr)
                REG_CTRL:         wb_dat_r <= wb_data_t'(run);
                REG_RATE_DIV:     wb_dat_r <= wb_data_t'(rate_div);
                REG_SAMPLE_COUNT: wb_dat_r <= sample_count;
                default:          wb_dat_r <= '0;
            endcase
        end
    end

endmodule

/* source/rate_strobe_gen.sv */
`timescale 1ns/10ps

module rate_strobe_gen (
    input  logic                    sys_clk,
    input  logic                    reset,
    input  logic                    run,
    input  halfband_pkg::rate_div_t rate_div,
    output logic                    out_en,
    output logic                    mid_en,
    output logic                    in_en
);
    import halfband_pkg::*;

    rate_div_t  div_cnt;
    logic [1:0] phase;

    // down-counter sets the output rate, phase splits it by two and four.
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            div_cnt <= '0;
            phase   <= '0;
        end else if (!run) begin
            // stopped, start again from a full period at phase zero.
            div_cnt <= rate_div;
            phase   <= '0;
        end else if (div_cnt == '0) begin
            div_cnt <= rate_div;
            phase   <= phase + 2'd1;
        end else begin
            div_cnt <= div_cnt - 1'b1;
        end
    end

    assign out_en = run && (div_cnt == '0);

    // every second output tick.
    assign mid_en = out_en && !phase[0];

    // every fourth, lined up with mid_en.
    assign in_en  = out_en && (phase == 2'd0);

endmodule

/* halfband/zero_stuffer.sv */
`timescale 1ns/10ps

module zero_stuffer (
    input  logic                  sys_clk,
    input  logic                  reset,
    input  logic                  load_en,
    input  logic                  fast_en,
    input  halfband_pkg::sample_t din,
    output halfband_pkg::sample_t dout
);
    import halfband_pkg::*;

    sample_t held;
    logic    zero_phase;

    // new sample restarts the pair, sample first.
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            held       <= '0;
            zero_phase <= 1'b1;
        end else if (load_en) begin
            held       <= din;
            zero_phase <= 1'b0;
        end else if (fast_en) begin
            zero_phase <= ~zero_phase;
        end
    end

    // zero inserted on every other fast tick.
    assign dout = zero_phase ? sample_t'(0) : held;

endmodule

/* halfband/halfband_sym_filter.sv */
`timescale 1ns/10ps

module halfband_sym_filter #(
    parameter halfband_pkg::coef_set_t COEFS = halfband_pkg::HB1_COEFS
) (
    input  logic                  sys_clk,
    input  logic                  reset,
    input  logic                  sample_en,
    input  halfband_pkg::sample_t x_in,
    output halfband_pkg::sample_t y
);
    import halfband_pkg::*;

    localparam int TAPS  = 7;
    localparam int PAIRS = (TAPS + 1) / 2;
    localparam int LVL2  = PAIRS / 2;

    // 2s34 product, bits 34..17 give back a 2s16 term.
    localparam int PROD_HI = PROD_W - 2;
    localparam int PROD_LO = PROD_HI - SAMPLE_W + 1;

    sample_t  x_dly [0:TAPS-1];
    sample_t  sum_1 [0:PAIRS-1];
    product_t mult  [0:PAIRS-1];
    sample_t  sum_2 [0:LVL2-1];
    sample_t  sum_3;

    // delay line, input halved to 2s16 for headroom.
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int i = 0; i < TAPS; i++) begin
                x_dly[i] <= '0;
            end
        end else if (sample_en) begin
            x_dly[0] <= x_in >>> 1;
            for (int i = 1; i < TAPS; i++) begin
                x_dly[i] <= x_dly[i-1];
            end
        end
    end

    // symmetric pre-add.
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int i = 0; i < PAIRS; i++) begin
                sum_1[i] <= '0;
            end
        end else if (sample_en) begin
            for (int i = 0; i < PAIRS - 1; i++) begin
                sum_1[i] <= x_dly[i] + x_dly[TAPS-1-i];
            end
            // centre tap has no partner.
            sum_1[PAIRS-1] <= x_dly[PAIRS-1];
        end
    end

    always_comb begin
        for (int i = 0; i < PAIRS; i++) begin
            mult[i] = coef_t'(COEFS[i]) * sum_1[i];
        end
    end

    // first adder level, wraps at 18 bits.
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int i = 0; i < LVL2; i++) begin
                sum_2[i] <= '0;
            end
        end else if (sample_en) begin
            for (int i = 0; i < LVL2; i++) begin
                sum_2[i] <= sample_t'(mult[2*i][PROD_HI:PROD_LO])
                          + sample_t'(mult[2*i+1][PROD_HI:PROD_LO]);
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            sum_3 <= '0;
        end else if (sample_en) begin
            sum_3 <= sum_2[0] + sum_2[1];
        end
    end

    // output holds between ticks.
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            y <= '0;
        end else if (sample_en) begin
            y <= sum_3;
        end
    end

endmodule

/* common/halfband_pkg.sv */
package halfband_pkg;

    // datapath widths.
    localparam int SAMPLE_W   = 18;
    localparam int COEF_W     = 18;
    localparam int PROD_W     = SAMPLE_W + COEF_W;

    // control bus widths.
    localparam int WB_ADDR_W  = 4;
    localparam int WB_DATA_W  = 32;
    localparam int RATE_DIV_W = 16;

    // 2s16 inside the filter after input halving.
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    // 0s18 coefficient.
    typedef logic signed [COEF_W-1:0]   coef_t;
    typedef logic signed [PROD_W-1:0]   product_t;

    // outer tap, next tap, inner tap, centre tap.
    typedef coef_t [0:3] coef_set_t;

    typedef logic [WB_ADDR_W-1:0]  wb_addr_t;
    typedef logic [WB_DATA_W-1:0]  wb_data_t;
    typedef logic [RATE_DIV_W-1:0] rate_div_t;

    // stage 1 halfband.
    localparam coef_set_t HB1_COEFS = {
        -18'sd9488, 18'sd0, 18'sd74902, 18'sd131071
    };

    // stage 2 halfband, a touch wider transition band.
    localparam coef_set_t HB2_COEFS = {
        -18'sd8192, 18'sd0, 18'sd73728, 18'sd131071
    };

    // register map, word addresses.
    localparam wb_addr_t REG_CTRL         = 4'd0;
    localparam wb_addr_t REG_RATE_DIV     = 4'd1;
    localparam wb_addr_t REG_SAMPLE_COUNT = 4'd2;

endpackage
